// File: core_defines.svh
/* Widths are fixed for RV32I. Only XLEN = 32 and ILEN = 32 are supported */

`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data and instruction widths
`define XLEN 32
`define ILEN 32

// Integer register file
`define NB_REGS 32
`define REG_ADDR_W 5

// First fetch address after reset
`define BOOT_ADDR 32'h0000_0000

// AXI4-Lite response code for a good transfer
`define AXI_RESP_OKAY 2'b00

`endif

// File: rv_isa_pkg.sv
/* RV32I subset types: OP, OP-IMM, LUI and SW only */

`include "core_defines.svh"

package rv_isa_pkg;

    typedef logic [`XLEN-1:0]       xlen_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // Decoded instruction with operands already read
    typedef struct packed {
        alu_op_e   alu_op;
        xlen_t     op_a;
        xlen_t     op_b;
        reg_addr_t rd;
        logic      wr_en;
        logic      store;
        xlen_t     store_data;
        logic      illegal;
    } dec_inst_t;

    // Value holds the ALU result, or the address for a store
    typedef struct packed {
        reg_addr_t rd;
        logic      wr_en;
        logic      store;
        xlen_t     value;
        xlen_t     store_data;
        logic      illegal;
    } exe_result_t;

endpackage

// File: axi_lite_pkg.sv
/* AXI4-Lite channel payloads. No ID, PROT or burst fields */

`include "core_defines.svh"

package axi_lite_pkg;

    typedef logic [1:0] axi_resp_t;

    ////////////////////
    // Address channel, used for both AR and AW
    ////////////////////
    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic             valid;
    } axi_addr_req_t;

    ////////////////////
    // Write data channel
    ////////////////////
    typedef struct packed {
        logic [`XLEN-1:0]   data;
        logic [`XLEN/8-1:0] strb;
        logic               valid;
    } axi_wdata_req_t;

endpackage

// File: reg_file.sv
/* Combinational reads, one synchronous write. x0 is never written */

`timescale 1ns/1ns

`include "core_defines.svh"

module reg_file (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  rv_isa_pkg::reg_addr_t rs1_addr,
    input  rv_isa_pkg::reg_addr_t rs2_addr,
    output rv_isa_pkg::xlen_t     rs1_val,
    output rv_isa_pkg::xlen_t     rs2_val,
    input  logic                  wr_en,
    input  rv_isa_pkg::reg_addr_t wr_addr,
    input  rv_isa_pkg::xlen_t     wr_data
);

    import rv_isa_pkg::*;

    xlen_t regs [`NB_REGS];

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NB_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // x0 forced to zero on the read side as well
    assign rs1_val = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_val = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: fetch_unit.sv
/* One instruction read at a time. The next read waits for retire
   and a halt stops all further reads */

`timescale 1ns/1ns

`include "core_defines.svh"

module fetch_unit (
    input  logic                       aclk,
    input  logic                       rst_n,
    output axi_lite_pkg::axi_addr_req_t imem_ar,
    input  logic                       imem_arready,
    input  logic                       imem_rvalid,
    output logic                       imem_rready,
    input  rv_isa_pkg::xlen_t          imem_rdata,
    input  axi_lite_pkg::axi_resp_t    imem_rresp,
    input  logic                       retire,
    input  logic                       halted,
    output logic                       inst_valid,
    output rv_isa_pkg::xlen_t          inst,
    output logic                       fetch_err
);

    import axi_lite_pkg::*;

    typedef enum logic [1:0] {
        REQ,
        WAIT_DATA,
        WAIT_RETIRE
    } fetch_state_e;

    fetch_state_e  state;
    axi_addr_req_t ar_q;
    logic          rdata_fire;

    // The AR address is the program counter itself
    assign imem_ar     = ar_q;
    assign imem_rready = (state == WAIT_DATA);
    assign rdata_fire  = imem_rvalid && imem_rready;

    // Read data goes straight to decode in the cycle it is accepted
    assign inst_valid = rdata_fire && (imem_rresp == `AXI_RESP_OKAY);
    assign inst       = imem_rdata;
    assign fetch_err  = rdata_fire && (imem_rresp != `AXI_RESP_OKAY);

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state      <= REQ;
            ar_q.addr  <= `BOOT_ADDR;
            ar_q.valid <= 1'b0;
        end else begin
            case (state)
                REQ: begin
                    if (ar_q.valid) begin
                        if (imem_arready) begin
                            ar_q.valid <= 1'b0;
                            state      <= WAIT_DATA;
                        end
                    end else if (!halted) begin
                        // First request after reset
                        ar_q.valid <= 1'b1;
                    end
                end
                WAIT_DATA: begin
                    if (imem_rvalid) begin
                        state <= WAIT_RETIRE;
                    end
                end
                WAIT_RETIRE: begin
                    // A fetch error never retires, so the unit parks here
                    if (retire && !halted) begin
                        ar_q.addr  <= ar_q.addr + `XLEN'd4;
                        ar_q.valid <= 1'b1;
                        state      <= REQ;
                    end
                end
                default: state <= REQ;
            endcase
        end
    end

endmodule

// File: decode_unit.sv
/* Decodes OP, OP-IMM, LUI and SW only. Anything else is flagged illegal
   and carries no register write and no store */

`timescale 1ns/1ns

`include "core_defines.svh"

module decode_unit (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  logic                  inst_valid,
    input  logic [`ILEN-1:0]      inst,
    input  logic                  wr_en,
    input  rv_isa_pkg::reg_addr_t wr_addr,
    input  rv_isa_pkg::xlen_t     wr_data,
    output logic                  dec_valid,
    output rv_isa_pkg::dec_inst_t dec
);

    import rv_isa_pkg::*;

    opcode_e   opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t     imm_i;
    xlen_t     imm_s;
    xlen_t     imm_u;
    xlen_t     rs1_val;
    xlen_t     rs2_val;
    dec_inst_t dec_next;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    ////////////////////
    // Immediates
    ////////////////////
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {inst[31:12], 12'b0};

    reg_file u_reg_file (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .rs1_addr (inst[19:15]),
        .rs2_addr (inst[24:20]),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    // funct3 picks the operation, alt selects sub or sra
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        dec_next            = '0;
        dec_next.alu_op     = ALU_ADD;
        dec_next.op_a       = rs1_val;
        dec_next.op_b       = imm_i;
        dec_next.rd         = inst[11:7];
        dec_next.store_data = rs2_val;
        case (opcode)
            OP: begin
                dec_next.alu_op  = alu_sel(funct3, funct7[5]);
                dec_next.op_b    = rs2_val;
                dec_next.wr_en   = 1'b1;
                dec_next.illegal = !((funct7 == 7'b0000000) ||
                                     ((funct7 == 7'b0100000) &&
                                      ((funct3 == 3'b000) || (funct3 == 3'b101))));
            end
            OP_IMM: begin
                dec_next.alu_op = alu_sel(funct3, (funct3 == 3'b101) && funct7[5]);
                dec_next.wr_en  = 1'b1;
                // Shift amounts only, upper bits must be a valid funct7
                if (funct3 == 3'b001) begin
                    dec_next.illegal = (funct7 != 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    dec_next.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end
            end
            LUI: begin
                dec_next.op_a  = '0;
                dec_next.op_b  = imm_u;
                dec_next.wr_en = 1'b1;
            end
            STORE: begin
                dec_next.op_b    = imm_s;
                dec_next.store   = 1'b1;
                dec_next.illegal = (funct3 != 3'b010);
            end
            default: dec_next.illegal = 1'b1;
        endcase
        if (dec_next.illegal) begin
            dec_next.wr_en = 1'b0;
            dec_next.store = 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= inst_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (inst_valid) begin
            dec <= dec_next;
        end
    end

endmodule

// File: execute_unit.sv
/* Registered ALU. A store uses the adder for its address */

`timescale 1ns/1ns

`include "core_defines.svh"

module execute_unit (
    input  logic                    aclk,
    input  logic                    rst_n,
    input  logic                    dec_valid,
    input  rv_isa_pkg::dec_inst_t   dec,
    output logic                    exe_valid,
    output rv_isa_pkg::exe_result_t exe
);

    import rv_isa_pkg::*;

    logic [4:0]  shamt;
    xlen_t       alu_res;
    exe_result_t exe_next;

    assign shamt = dec.op_b[4:0];

    ////////////////////
    // ALU
    ////////////////////
    // LUI arrives as zero plus the U-immediate
    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_res = dec.op_a + dec.op_b;
            ALU_SUB:  alu_res = dec.op_a - dec.op_b;
            ALU_SLL:  alu_res = dec.op_a << shamt;
            ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}}, $signed(dec.op_a) < $signed(dec.op_b)};
            ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, dec.op_a < dec.op_b};
            ALU_XOR:  alu_res = dec.op_a ^ dec.op_b;
            ALU_SRL:  alu_res = dec.op_a >> shamt;
            ALU_SRA:  alu_res = $signed(dec.op_a) >>> shamt;
            ALU_OR:   alu_res = dec.op_a | dec.op_b;
            default:  alu_res = dec.op_a & dec.op_b;
        endcase
    end

    always_comb begin
        exe_next.rd         = dec.rd;
        exe_next.wr_en      = dec.wr_en;
        exe_next.store      = dec.store;
        exe_next.value      = alu_res;
        exe_next.store_data = dec.store_data;
        exe_next.illegal    = dec.illegal;
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (dec_valid) begin
            exe <= exe_next;
        end
    end

endmodule

// File: result_unit.sv
/* Retires one instruction at a time. The first halt cause is kept
   and the core stays halted until reset */

`timescale 1ns/1ns

`include "core_defines.svh"

module result_unit (
    input  logic                        aclk,
    input  logic                        rst_n,
    input  logic                        exe_valid,
    input  rv_isa_pkg::exe_result_t     exe,
    output axi_lite_pkg::axi_addr_req_t  dmem_aw,
    input  logic                        dmem_awready,
    output axi_lite_pkg::axi_wdata_req_t dmem_w,
    input  logic                        dmem_wready,
    input  logic                        dmem_bvalid,
    output logic                        dmem_bready,
    input  axi_lite_pkg::axi_resp_t     dmem_bresp,
    input  logic                        fetch_err,
    output logic                        wr_en,
    output rv_isa_pkg::reg_addr_t       wr_addr,
    output rv_isa_pkg::xlen_t           wr_data,
    output logic                        retire,
    output logic                        halted,
    output logic [1:0]                  halt_cause
);

    import axi_lite_pkg::*;

    typedef enum logic [1:0] {IDLE, STORE, WAIT_B} res_state_e;
    typedef enum logic [1:0] {NONE, ILLEGAL, FETCH_ERR, STORE_ERR} halt_cause_e;

    res_state_e     state;
    halt_cause_e    cause_q;
    logic           halt_q;
    axi_addr_req_t  aw_q;
    axi_wdata_req_t w_q;
    logic           aw_done;
    logic           w_done;
    logic           b_fire;

    assign dmem_aw     = aw_q;
    assign dmem_w      = w_q;
    assign dmem_bready = (state == WAIT_B);
    assign b_fire      = dmem_bvalid && dmem_bready;

    // A channel is done once its handshake happened, now or earlier
    assign aw_done = !aw_q.valid || dmem_awready;
    assign w_done  = !w_q.valid || dmem_wready;

    // Register results are written in the cycle they arrive
    assign wr_en   = exe_valid && exe.wr_en;
    assign wr_addr = exe.rd;
    assign wr_data = exe.value;
    assign retire  = wr_en || (b_fire && (dmem_bresp == `AXI_RESP_OKAY));

    assign halted     = halt_q;
    assign halt_cause = cause_q;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state     <= IDLE;
            aw_q.valid <= 1'b0;
            w_q.valid <= 1'b0;
            halt_q    <= 1'b0;
            cause_q   <= NONE;
        end else begin
            case (state)
                IDLE: begin
                    if (exe_valid && exe.store) begin
                        aw_q  <= '{addr: exe.value, valid: 1'b1};
                        w_q   <= '{data: exe.store_data, strb: '1, valid: 1'b1};
                        state <= STORE;
                    end
                end
                STORE: begin
                    if (dmem_awready) aw_q.valid <= 1'b0;
                    if (dmem_wready) w_q.valid <= 1'b0;
                    if (aw_done && w_done) state <= WAIT_B;
                end
                WAIT_B: begin
                    if (dmem_bvalid) state <= IDLE;
                end
                default: state <= IDLE;
            endcase

            if (!halt_q) begin
                if (exe_valid && exe.illegal) begin
                    halt_q  <= 1'b1;
                    cause_q <= ILLEGAL;
                end else if (fetch_err) begin
                    halt_q  <= 1'b1;
                    cause_q <= FETCH_ERR;
                end else if (b_fire && (dmem_bresp != `AXI_RESP_OKAY)) begin
                    halt_q  <= 1'b1;
                    cause_q <= STORE_ERR;
                end
            end
        end
    end

endmodule

// File: rv32i_core.sv
/* RV32I subset core with one instruction in flight. AXI4-Lite read port
   for instructions, write-only AXI4-Lite port for stores */

`timescale 1ns/1ns

module rv32i_core (
    input  logic                        aclk,
    input  logic                        rst_n,
    // Instruction read channel
    output axi_lite_pkg::axi_addr_req_t  imem_ar,
    input  logic                        imem_arready,
    input  logic                        imem_rvalid,
    output logic                        imem_rready,
    input  rv_isa_pkg::xlen_t           imem_rdata,
    input  axi_lite_pkg::axi_resp_t     imem_rresp,
    // Data write channel
    output axi_lite_pkg::axi_addr_req_t  dmem_aw,
    input  logic                        dmem_awready,
    output axi_lite_pkg::axi_wdata_req_t dmem_w,
    input  logic                        dmem_wready,
    input  logic                        dmem_bvalid,
    output logic                        dmem_bready,
    input  axi_lite_pkg::axi_resp_t     dmem_bresp,
    // Status
    output logic                        halted,
    output logic [1:0]                  halt_cause
);

    import rv_isa_pkg::*;

    logic        inst_valid;
    xlen_t       inst;
    logic        fetch_err;
    logic        dec_valid;
    dec_inst_t   dec;
    logic        exe_valid;
    exe_result_t exe;
    logic        wr_en;
    reg_addr_t   wr_addr;
    xlen_t       wr_data;
    logic        retire;

    fetch_unit u_fetch (
        .aclk (aclk), .rst_n (rst_n),
        .imem_ar (imem_ar), .imem_arready (imem_arready),
        .imem_rvalid (imem_rvalid), .imem_rready (imem_rready),
        .imem_rdata (imem_rdata), .imem_rresp (imem_rresp),
        .retire (retire), .halted (halted),
        .inst_valid (inst_valid), .inst (inst), .fetch_err (fetch_err)
    );

    decode_unit u_decode (
        .aclk (aclk), .rst_n (rst_n),
        .inst_valid (inst_valid), .inst (inst),
        .wr_en (wr_en), .wr_addr (wr_addr), .wr_data (wr_data),
        .dec_valid (dec_valid), .dec (dec)
    );

    execute_unit u_execute (
        .aclk (aclk), .rst_n (rst_n),
        .dec_valid (dec_valid), .dec (dec),
        .exe_valid (exe_valid), .exe (exe)
    );

    result_unit u_result (
        .aclk (aclk), .rst_n (rst_n),
        .exe_valid (exe_valid), .exe (exe),
        .dmem_aw (dmem_aw), .dmem_awready (dmem_awready),
        .dmem_w (dmem_w), .dmem_wready (dmem_wready),
        .dmem_bvalid (dmem_bvalid), .dmem_bready (dmem_bready), .dmem_bresp (dmem_bresp),
        .fetch_err (fetch_err),
        .wr_en (wr_en), .wr_addr (wr_addr), .wr_data (wr_data),
        .retire (retire), .halted (halted), .halt_cause (halt_cause)
    );

endmodule

// File: rv32i_core_sva.sv
/* AXI4-Lite request checks on the core ports. Off while rst_n is low */

`timescale 1ns/1ns

module rv32i_core_sva (
    input logic                         aclk,
    input logic                         rst_n,
    input axi_lite_pkg::axi_addr_req_t  imem_ar,
    input logic                         imem_arready,
    input axi_lite_pkg::axi_addr_req_t  dmem_aw,
    input logic                         dmem_awready,
    input axi_lite_pkg::axi_wdata_req_t dmem_w,
    input logic                         dmem_wready,
    input logic                         halted
);

    // Valid and payload hold until the handshake
    ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        imem_ar.valid && !imem_arready |=> $stable(imem_ar))
        else $error("AR request changed before arready");

    aw_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        dmem_aw.valid && !dmem_awready |=> $stable(dmem_aw))
        else $error("AW request changed before awready");

    w_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        dmem_w.valid && !dmem_wready |=> $stable(dmem_w))
        else $error("W data changed before wready");

    // A halted core raises no new request
    ar_halt: assert property (@(posedge aclk) disable iff (!rst_n)
        halted |-> !imem_ar.valid)
        else $error("AR valid while halted");

    aw_halt: assert property (@(posedge aclk) disable iff (!rst_n)
        halted |-> !dmem_aw.valid)
        else $error("AW valid while halted");

endmodule

bind rv32i_core rv32i_core_sva u_sva (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .imem_ar      (imem_ar),
    .imem_arready (imem_arready),
    .dmem_aw      (dmem_aw),
    .dmem_awready (dmem_awready),
    .dmem_w       (dmem_w),
    .dmem_wready  (dmem_wready),
    .halted       (halted)
);

// File: rv32i_core_tb.sv
/* A random 200-instruction program that ends on an illegal word, then a reset
   and an error response on the fifth instruction read */

`timescale 1ns/1ns

`include "core_defines.svh"

module rv32i_core_tb;

    import rv_isa_pkg::*;
    import axi_lite_pkg::*;

    localparam int PROG_LEN   = 200;
    localparam int MAX_CYCLES = PROG_LEN * 20;
    localparam int K_SW       = 0;
    localparam int K_OP       = 1;
    localparam int K_IMM      = 2;
    localparam int K_LUI      = 3;

    logic           aclk;
    logic           rst_n        = 1'b0;
    axi_addr_req_t  imem_ar;
    logic           imem_arready = 1'b0;
    logic           imem_rvalid  = 1'b0;
    logic           imem_rready;
    xlen_t          imem_rdata   = '0;
    axi_resp_t      imem_rresp   = '0;
    axi_addr_req_t  dmem_aw;
    logic           dmem_awready = 1'b0;
    axi_wdata_req_t dmem_w;
    logic           dmem_wready  = 1'b0;
    logic           dmem_bvalid  = 1'b0;
    logic           dmem_bready;
    axi_resp_t      dmem_bresp   = '0;
    logic           halted;
    logic [1:0]     halt_cause;

    // Program fields for the reference model
    int        kind  [PROG_LEN];
    int        op_f  [PROG_LEN];
    reg_addr_t rd_f  [PROG_LEN];
    reg_addr_t rs1_f [PROG_LEN];
    reg_addr_t rs2_f [PROG_LEN];
    xlen_t     imm_f [PROG_LEN];
    xlen_t     imem  [256];
    xlen_t     exp_addr [$];
    xlen_t     exp_data [$];

    int    seed_val;
    int    cycle_cnt  = 0;
    int    fetch_cnt  = 0;
    int    err_fetch  = -1;
    int    rd_idx     = 0;
    xlen_t rd_addr    = '0;
    logic  rd_pending = 1'b0;
    int    ar_wait    = 0;
    int    r_wait     = 0;
    int    aw_wait    = 0;
    int    w_wait     = 0;
    int    b_wait     = 0;
    logic  aw_seen    = 1'b0;
    logic  w_seen     = 1'b0;
    xlen_t st_addr    = '0;
    xlen_t st_data    = '0;

    rv32i_core UUT (
        .aclk (aclk), .rst_n (rst_n),
        .imem_ar (imem_ar), .imem_arready (imem_arready),
        .imem_rvalid (imem_rvalid), .imem_rready (imem_rready),
        .imem_rdata (imem_rdata), .imem_rresp (imem_rresp),
        .dmem_aw (dmem_aw), .dmem_awready (dmem_awready),
        .dmem_w (dmem_w), .dmem_wready (dmem_wready),
        .dmem_bvalid (dmem_bvalid), .dmem_bready (dmem_bready), .dmem_bresp (dmem_bresp),
        .halted (halted), .halt_cause (halt_cause)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            abort_run("Timeout: the core did not reach its halt in time");
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////
    // Op numbers 0 to 9 are add sub sll slt sltu xor srl sra or and
    function automatic xlen_t alu_ref(input int op, input xlen_t a, input xlen_t b);
        case (op)
            0: return a + b;
            1: return a - b;
            2: return a << b[4:0];
            3: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4: return (a < b) ? 32'd1 : 32'd0;
            5: return a ^ b;
            6: return a >> b[4:0];
            7: return $signed(a) >>> b[4:0];
            8: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [2:0] funct3_of(input int op);
        case (op)
            0, 1: return 3'd0;
            2: return 3'd1;
            3: return 3'd2;
            4: return 3'd3;
            5: return 3'd4;
            6, 7: return 3'd5;
            8: return 3'd6;
            default: return 3'd7;
        endcase
    endfunction

    function automatic xlen_t encode(input int i);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = funct3_of(op_f[i]);
        f7 = (op_f[i] == 1 || op_f[i] == 7) ? 7'h20 : 7'h00;
        case (kind[i])
            K_SW:  return {imm_f[i][11:5], rs2_f[i], rs1_f[i], 3'b010, imm_f[i][4:0], 7'b0100011};
            K_OP:  return {f7, rs2_f[i], rs1_f[i], f3, rd_f[i], 7'b0110011};
            K_IMM: return {imm_f[i][11:0], rs1_f[i], f3, rd_f[i], 7'b0010011};
            default: return {imm_f[i][31:12], rd_f[i], 7'b0110111};
        endcase
    endfunction

    // Runs the first n_inst instructions and queues the stores they make
    task automatic run_model(input int n_inst);
        xlen_t regs_m [32];
        xlen_t res;
        for (int r = 0; r < 32; r++) begin
            regs_m[r] = '0;
        end
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < n_inst; i++) begin
            res = '0;
            case (kind[i])
                K_SW: begin
                    exp_addr.push_back(regs_m[rs1_f[i]] + imm_f[i]);
                    exp_data.push_back(regs_m[rs2_f[i]]);
                end
                K_OP:  res = alu_ref(op_f[i], regs_m[rs1_f[i]], regs_m[rs2_f[i]]);
                K_IMM: res = alu_ref(op_f[i], regs_m[rs1_f[i]], imm_f[i]);
                default: res = imm_f[i];
            endcase
            if (kind[i] != K_SW && rd_f[i] != 5'd0) begin
                regs_m[rd_f[i]] = res;
            end
        end
    endtask

    // About a quarter stores and only x0 to x7 so results get stored often
    task automatic gen_program();
        int          sel;
        logic [11:0] imm12;
        for (int i = 0; i < PROG_LEN; i++) begin
            sel      = $urandom_range(0, 99);
            rd_f[i]  = reg_addr_t'($urandom_range(0, 7));
            rs1_f[i] = reg_addr_t'($urandom_range(0, 7));
            rs2_f[i] = reg_addr_t'($urandom_range(0, 7));
            imm12    = 12'($urandom);
            imm_f[i] = {{20{imm12[11]}}, imm12};
            op_f[i]  = 0;
            if (sel < 25) begin
                kind[i] = K_SW;
            end else if (sel < 55) begin
                kind[i] = K_OP;
                op_f[i] = $urandom_range(0, 9);
            end else if (sel < 90) begin
                kind[i] = K_IMM;
                op_f[i] = $urandom_range(0, 8);
                if (op_f[i] != 0) begin
                    op_f[i] = op_f[i] + 1;
                end
                // Shift immediates carry funct7 in the upper bits
                if (op_f[i] == 2 || op_f[i] == 6) begin
                    imm_f[i] = {27'd0, imm12[4:0]};
                end else if (op_f[i] == 7) begin
                    imm_f[i] = {20'd0, 7'h20, imm12[4:0]};
                end
            end else begin
                kind[i]  = K_LUI;
                imm_f[i] = $urandom() & 32'hffff_f000;
            end
        end
        // Write x0 first and then store from x0
        kind[0]  = K_IMM;
        op_f[0]  = 0;
        rd_f[0]  = 5'd0;
        imm_f[0] = 32'd123;
        kind[1]  = K_SW;
        rs2_f[1] = 5'd0;
        // Store offsets are 12-bit signed
        imm_f[1] = {{20{imm_f[1][11]}}, imm_f[1][11:0]};
        // Opcode 7'h7f is illegal so stray fetches halt the core
        for (int a = 0; a < 256; a++) begin
            imem[a] = {a[24:0], 7'h7f};
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            imem[i] = encode(i);
        end
        imem[PROG_LEN] = 32'h0000_0000;
    endtask

    ////////////////////
    // AXI responders
    ////////////////////
    always @(posedge aclk) begin
        if (!rst_n) begin
            imem_arready <= 1'b0;
            imem_rvalid  <= 1'b0;
            rd_pending = 1'b0;
            fetch_cnt  = 0;
        end else begin
            if (halted) begin
                check_value("imem_ar.valid", 32'(imem_ar.valid), 32'd0);
            end
            if (imem_ar.valid && imem_arready) begin
                check_value("imem_ar.addr", imem_ar.addr, `BOOT_ADDR + 32'(fetch_cnt) * 32'd4);
                imem_arready <= 1'b0;
                rd_addr    = imem_ar.addr;
                rd_idx     = fetch_cnt;
                fetch_cnt  = fetch_cnt + 1;
                rd_pending = 1'b1;
            end else if (imem_ar.valid) begin
                if (ar_wait == 0) begin
                    imem_arready <= 1'b1;
                    ar_wait = $urandom_range(0, 3);
                end else begin
                    ar_wait = ar_wait - 1;
                end
            end
            if (imem_rvalid && imem_rready) begin
                imem_rvalid <= 1'b0;
            end else if (rd_pending) begin
                if (r_wait == 0) begin
                    imem_rvalid <= 1'b1;
                    imem_rdata  <= imem[rd_addr[9:2]];
                    imem_rresp  <= (rd_idx == err_fetch) ? 2'b10 : `AXI_RESP_OKAY;
                    rd_pending = 1'b0;
                    r_wait     = $urandom_range(0, 3);
                end else begin
                    r_wait = r_wait - 1;
                end
            end
        end
    end

    always @(posedge aclk) begin
        if (!rst_n) begin
            dmem_awready <= 1'b0;
            dmem_wready  <= 1'b0;
            dmem_bvalid  <= 1'b0;
            aw_seen = 1'b0;
            w_seen  = 1'b0;
        end else begin
            if (dmem_aw.valid && dmem_awready) begin
                dmem_awready <= 1'b0;
                aw_seen = 1'b1;
                st_addr = dmem_aw.addr;
            end else if (dmem_aw.valid) begin
                if (aw_wait == 0) begin
                    dmem_awready <= 1'b1;
                    aw_wait = $urandom_range(0, 3);
                end else begin
                    aw_wait = aw_wait - 1;
                end
            end
            if (dmem_w.valid && dmem_wready) begin
                check_value("dmem_w.strb", 32'(dmem_w.strb), 32'hf);
                dmem_wready <= 1'b0;
                w_seen  = 1'b1;
                st_data = dmem_w.data;
            end else if (dmem_w.valid) begin
                if (w_wait == 0) begin
                    dmem_wready <= 1'b1;
                    w_wait = $urandom_range(0, 3);
                end else begin
                    w_wait = w_wait - 1;
                end
            end
            // Response only after both address and data were taken
            if (dmem_bvalid && dmem_bready) begin
                dmem_bvalid <= 1'b0;
            end else if (aw_seen && w_seen && !dmem_bvalid) begin
                if (b_wait == 0) begin
                    if (exp_addr.size() == 0) begin
                        abort_run("The core issued a store that the model does not expect");
                    end else begin
                        check_value("dmem_aw.addr", st_addr, exp_addr.pop_front());
                        check_value("dmem_w.data", st_data, exp_data.pop_front());
                    end
                    dmem_bvalid <= 1'b1;
                    dmem_bresp  <= `AXI_RESP_OKAY;
                    aw_seen = 1'b0;
                    w_seen  = 1'b0;
                    b_wait  = $urandom_range(0, 3);
                end else begin
                    b_wait = b_wait - 1;
                end
            end
        end
    end

    ////////////////////
    // Run sequence
    ////////////////////
    task automatic apply_reset();
        rst_n <= 1'b0;
        repeat (5) @(posedge aclk);
        rst_n <= 1'b1;
    endtask

    task automatic wait_halt();
        @(posedge aclk);
        while (!halted) begin
            @(posedge aclk);
        end
    endtask

    initial begin
        seed_val = $urandom(32'ha011);
        gen_program();

        // Whole program up to the illegal word that halts the core
        run_model(PROG_LEN);
        apply_reset();
        wait_halt();
        check_value("halt_cause", 32'(halt_cause), 32'd1);
        repeat (20) @(posedge aclk);
        check_value("fetch count", fetch_cnt, PROG_LEN + 1);
        check_value("stores left", exp_addr.size(), 0);

        // Fifth read answered with SLVERR
        err_fetch = 4;
        run_model(4);
        apply_reset();
        wait_halt();
        check_value("halt_cause", 32'(halt_cause), 32'd2);
        repeat (20) @(posedge aclk);
        check_value("fetch count", fetch_cnt, 5);
        check_value("stores left", exp_addr.size(), 0);

        $display("No errors");
        $finish;
    end

endmodule

// File: list.f
+incdir+.
rv_isa_pkg.sv
axi_lite_pkg.sv
reg_file.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
result_unit.sv
rv32i_core.sv
rv32i_core_sva.sv
rv32i_core_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module rv32i_core_tb -f list.f -o sim_core
./obj_dir/sim_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
    exit 1
fi
if ! grep -q "No errors" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
